//--- files.f
source/sys1_pkg.sv
source/rom_loader.sv
source/rom_bank_set.sv
source/gfx_mem_arbiter.sv
source/control_decoder.sv
source/sys1_rom_top.sv
sim/tb_sys1_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_sys1_top \
	-f files.f \
	-o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

# The run passes only when the testbench reported success
if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
fi
exit 1

//--- sim/tb_sys1_top.sv
`timescale 1ns/10ps

module tb_sys1_top import sys1_pkg::*; ();

	localparam int WAIT_LIMIT = 64;
	localparam int BANK_BYTES = 16;
	localparam int GFX_BYTES = 32;
	localparam load_addr_t GFX_BASE = 25'h000_0400;

	// Slot order matches held with P1 keys, P2 keys and then coins
	localparam logic [8:0] KEY_CODES [15] = '{
		KEY_P1_UP, KEY_P1_DOWN, KEY_P1_LEFT, KEY_P1_RIGHT, KEY_P1_WHIP, KEY_P1_JUMP,
		KEY_P2_UP, KEY_P2_DOWN, KEY_P2_LEFT, KEY_P2_RIGHT, KEY_P2_WHIP, KEY_P2_JUMP,
		KEY_COIN_L, KEY_COIN_R, KEY_COIN_AUX};

	// Main bank selects per slot for system ROM, ROM1, ROM3 and slapstic
	localparam logic [3:0] MAIN_SEL_N [4] = '{4'b1110, 4'b1101, 4'b0111, 4'b1111};
	localparam logic SLAP_SEL_N [4] = '{1'b1, 1'b1, 1'b1, 1'b0};

	logic        clk_sys;
	logic        reset;
	logic        load_download;
	logic        load_wr;
	byte_t       load_index;
	load_addr_t  load_addr;
	byte_t       load_data;
	logic        load_wait;
	main_addr_t  main_addr;
	logic [3:0]  rom_sel_n;
	logic        slap_sel_n;
	word_t       main_data;
	sound_addr_t sound_addr;
	logic [2:0]  sound_sel_n;
	byte_t       sound_data;
	gfx_addr_t   video_addr;
	dword_t      video_data;
	gfx_addr_t   gfx_mem_addr;
	dword_t      gfx_mem_wdata;
	logic        gfx_mem_we;
	dword_t      gfx_mem_rdata;
	logic        gfx_mem_ready;
	scancode_t   key_event;
	joy_t        joy0;
	joy_t        joy1;
	logic        service;
	byte_t       ctl_joy;
	logic [2:0]  ctl_coin_n;
	logic [4:0]  ctl_pb_n;
	logic        ctl_self_test_n;

	// Stimulus bytes with slots 0 to 3 for main banks and 4 to 6 for sound banks
	byte_t rom_bytes [7][BANK_BYTES];
	byte_t gfx_bytes [GFX_BYTES];
	logic [31:0] rng_state = 32'd79;
	logic [14:0] held = '0;
	byte_t exp_slap = 8'd105;

	// External graphics memory model
	dword_t    gfx_mem [gfx_addr_t];
	gfx_addr_t write_addr_q [$];
	dword_t    write_data_q [$];
	dword_t    pending_rdata = '0;
	logic      stall_enable = 1'b0;
	int        stall_count = 0;
	int        stall_cycles = 0;

	int tests_run = 0;
	int checks = 0;
	int errors = 0;

	sys1_rom_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = !clk_sys;
	end

	// ############################################################
	// Graphics memory model
	// ############################################################

	// Unwritten dwords read back a pattern of the full address
	function automatic dword_t fill_word(gfx_addr_t a);
		return {a, a[8:0]} ^ 32'hC3A5_5A3C;
	endfunction

	// Writes and read address are taken mid-cycle
	initial begin
		forever begin
			@(negedge clk_sys);
			if (gfx_mem_we) begin
				gfx_mem[gfx_mem_addr] = gfx_mem_wdata;
				write_addr_q.push_back(gfx_mem_addr);
				write_data_q.push_back(gfx_mem_wdata);
			end
			pending_rdata = gfx_mem.exists(gfx_mem_addr) ? gfx_mem[gfx_mem_addr]
			                                             : fill_word(gfx_mem_addr);
		end
	end

	// Read data and ready change just after the clock edge
	initial begin
		gfx_mem_ready = 1'b1;
		gfx_mem_rdata = '0;
		forever begin
			@(posedge clk_sys);
			#1;
			gfx_mem_rdata = pending_rdata;
			if (stall_enable) begin
				stall_count++;
				// Busy two cycles out of five
				gfx_mem_ready = (stall_count % 5) < 3;
			end else begin
				gfx_mem_ready = 1'b1;
			end
		end
	end

	// ############################################################
	// Helpers
	// ############################################################

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic load_addr_t region_base(int slot);
		case (slot)
			0: return REGION_ROM0;
			1: return REGION_ROM1;
			2: return REGION_ROM3;
			3: return REGION_SLAP;
			4: return REGION_SND0;
			5: return REGION_SND1;
			default: return REGION_SND2;
		endcase
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic stop_on_timeout(string what);
		$display("Timeout at %0d ns: %s never came", $time, what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic report_test(string name, int errs_at_start);
		tests_run++;
		$display("%-22s done, %0d errors", name, errors - errs_at_start);
	endtask

	// One host byte held back while the memory is busy
	task automatic send_byte(byte_t index, load_addr_t addr, byte_t data);
		int waited;
		waited = 0;
		while (load_wait && waited < WAIT_LIMIT) begin
			tick();
			waited++;
			stall_cycles++;
		end
		if (load_wait) begin
			stop_on_timeout("release of load_wait");
		end else begin
			load_index = index;
			load_addr  = addr;
			load_data  = data;
			load_wr    = 1'b1;
			tick();
			load_wr    = 1'b0;
		end
	endtask

	task automatic set_download(logic level);
		load_download = level;
		tick();
	endtask

	task automatic load_region(int slot);
		for (int i = 0; i < BANK_BYTES; i++) begin
			rng_state = xorshift32(rng_state);
			rom_bytes[slot][i] = rng_state[7:0];
			send_byte(INDEX_ROM, region_base(slot) + load_addr_t'(i), rom_bytes[slot][i]);
		end
	endtask

	task automatic read_main(main_addr_t addr, logic [3:0] sel_n, logic slap_n,
	                         output word_t data);
		main_addr  = addr;
		rom_sel_n  = sel_n;
		slap_sel_n = slap_n;
		tick();
		data = main_data;
	endtask

	task automatic read_sound(sound_addr_t addr, logic [2:0] sel_n, output byte_t data);
		sound_addr  = addr;
		sound_sel_n = sel_n;
		tick();
		data = sound_data;
	endtask

	// Key event with a fresh toggle tracked in the expected latches
	task automatic key(logic [8:0] code, logic down);
		key_event = {!key_event[10], down, code};
		for (int i = 0; i < 15; i++) begin
			if (KEY_CODES[i] == code) begin
				held[i] = down;
			end
		end
		tick();
	endtask

	task automatic check_controls();
		logic [3:0] dir;
		logic [7:0] exp_joy;
		logic [2:0] exp_coin;
		logic [4:0] exp_pb;
		dir = {held[0] | held[6], held[1] | held[7], held[2] | held[8], held[3] | held[9]};
		dir = dir | joy0[3:0] | joy1[3:0];
		exp_joy = (exp_slap == 8'd105) ? {3'b000, dir, 1'b0} : {4'b0000, dir};
		exp_coin = {!held[14], !held[13], !(held[12] || joy0[8])};
		exp_pb = {2'b11, !(held[11] || held[5] || joy1[5] || joy0[5]),
		          !(held[10] || joy1[5] || joy0[5]), !(held[4] || joy1[4] || joy0[4])};
		check_value("ctl_joy", ctl_joy, exp_joy);
		check_value("ctl_coin_n", ctl_coin_n, exp_coin);
		check_value("ctl_pb_n", ctl_pb_n, exp_pb);
		check_value("ctl_self_test_n", ctl_self_test_n, !service);
	endtask

	// ############################################################
	// Tests
	// ############################################################

	task automatic test_main_rom();
		int errs_at_start;
		word_t data;
		errs_at_start = errors;
		set_download(1'b1);
		for (int s = 0; s < 4; s++) begin
			load_region(s);
		end
		set_download(1'b0);
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < BANK_BYTES / 2; k++) begin
				read_main(main_addr_t'(k), MAIN_SEL_N[s], SLAP_SEL_N[s], data);
				check_value("main_data", data, {rom_bytes[s][2*k], rom_bytes[s][2*k+1]});
			end
		end
		// Priority between several low selects
		read_main(15'd3, 4'b0000, 1'b0, data);
		check_value("main_data", data, {rom_bytes[0][6], rom_bytes[0][7]});
		read_main(15'd3, 4'b0101, 1'b0, data);
		check_value("main_data", data, {rom_bytes[1][6], rom_bytes[1][7]});
		read_main(15'd3, 4'b0111, 1'b0, data);
		check_value("main_data", data, {rom_bytes[2][6], rom_bytes[2][7]});
		read_main(15'd3, 4'b1111, 1'b1, data);
		check_value("main_data", data, 32'h0);
		report_test("main rom", errs_at_start);
	endtask

	task automatic test_sound_rom();
		int errs_at_start;
		byte_t data;
		errs_at_start = errors;
		set_download(1'b1);
		for (int s = 4; s < 7; s++) begin
			load_region(s);
		end
		set_download(1'b0);
		for (int s = 0; s < 3; s++) begin
			for (int k = 0; k < BANK_BYTES; k++) begin
				read_sound(sound_addr_t'(k), ~(3'b001 << s), data);
				check_value("sound_data", data, rom_bytes[4+s][k]);
			end
		end
		read_sound(14'd5, 3'b000, data);
		check_value("sound_data", data, rom_bytes[4][5]);
		read_sound(14'd5, 3'b001, data);
		check_value("sound_data", data, rom_bytes[5][5]);
		read_sound(14'd5, 3'b111, data);
		check_value("sound_data", data, 32'h0);
		report_test("sound rom", errs_at_start);
	endtask

	task automatic test_gfx_pack();
		int errs_at_start;
		int waited;
		errs_at_start = errors;
		write_addr_q.delete();
		write_data_q.delete();
		stall_cycles = 0;
		stall_enable = 1'b1;
		set_download(1'b1);
		for (int i = 0; i < GFX_BYTES; i++) begin
			rng_state = xorshift32(rng_state);
			gfx_bytes[i] = rng_state[7:0];
			send_byte(INDEX_ROM, GFX_BASE + load_addr_t'(i), gfx_bytes[i]);
			check_value("load_wait", load_wait, !gfx_mem_ready);
		end
		set_download(1'b0);
		stall_enable = 1'b0;
		waited = 0;
		while (write_addr_q.size() < GFX_BYTES / 4 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (write_addr_q.size() < GFX_BYTES / 4) begin
			stop_on_timeout("the last graphics dword write");
		end else begin
			// Quiet period to catch any extra write
			repeat (4) tick();
			check_value("gfx write count", write_addr_q.size(), GFX_BYTES / 4);
			for (int j = 0; j < GFX_BYTES / 4 && j < write_addr_q.size(); j++) begin
				check_value("gfx_mem_addr", write_addr_q[j], (GFX_BASE >> 2) + j);
				check_value("gfx_mem_wdata", write_data_q[j], {gfx_bytes[4*j], gfx_bytes[4*j+1],
				            gfx_bytes[4*j+2], gfx_bytes[4*j+3]});
			end
			checks++;
			assert (stall_cycles > 0) else begin
				$display("The memory never held the host back during the download");
				errors++;
			end
			report_test("graphics packing", errs_at_start);
		end
	endtask

	task automatic test_arbitration();
		int errs_at_start;
		gfx_addr_t probe;
		dword_t expected;
		errs_at_start = errors;
		for (int j = 0; j < GFX_BYTES / 4 + 2; j++) begin
			if (j < GFX_BYTES / 4) begin
				probe = gfx_addr_t'((GFX_BASE >> 2) + j);
				expected = {gfx_bytes[4*j], gfx_bytes[4*j+1], gfx_bytes[4*j+2], gfx_bytes[4*j+3]};
			end else begin
				probe = (j == GFX_BYTES / 4) ? 23'h7F_F0F0 : 23'h00_0055;
				expected = fill_word(probe);
			end
			video_addr = probe;
			// Address must pass through within the same cycle
			#1;
			check_value("gfx_mem_addr", gfx_mem_addr, probe);
			check_value("gfx_mem_we", gfx_mem_we, 1'b0);
			tick();
			check_value("video_data", video_data, expected);
		end
		check_value("gfx write count", write_addr_q.size(), GFX_BYTES / 4);
		report_test("arbitration", errs_at_start);
	endtask

	task automatic test_controls();
		int errs_at_start;
		errs_at_start = errors;
		// Idle lines while no key has been pressed
		check_value("ctl_coin_n", ctl_coin_n, 3'b111);
		check_value("ctl_pb_n", ctl_pb_n, 5'b11111);
		check_controls();
		for (int i = 0; i < 15; i++) begin
			key(KEY_CODES[i], 1'b1);
			check_controls();
		end
		for (int i = 0; i < 15; i++) begin
			key(KEY_CODES[i], 1'b0);
			check_controls();
		end
		// Unlisted code leaves the latches alone
		key(9'h05A, 1'b1);
		check_controls();
		joy0 = 12'h100;
		tick();
		check_controls();
		joy1 = 12'h020;
		tick();
		check_controls();
		joy0 = 12'h015;
		joy1 = 12'h002;
		key(KEY_P2_WHIP, 1'b1);
		check_controls();
		service = 1'b1;
		key(KEY_P1_DOWN, 1'b1);
		check_controls();
		service = 1'b0;
		joy0 = '0;
		joy1 = '0;
		key(KEY_P2_WHIP, 1'b0);
		key(KEY_P1_DOWN, 1'b0);
		check_controls();
		report_test("controls", errs_at_start);
	endtask

	task automatic test_slap_type();
		int errs_at_start;
		errs_at_start = errors;
		joy0 = 12'h00A;
		tick();
		check_value("ctl_joy", ctl_joy, 8'b0001_0100);
		send_byte(INDEX_SLAP_TYPE, '0, 8'd103);
		exp_slap = 8'd103;
		tick();
		check_value("ctl_joy", ctl_joy, 8'b0000_1010);
		check_controls();
		send_byte(INDEX_SLAP_TYPE, '0, 8'd105);
		exp_slap = 8'd105;
		tick();
		check_value("ctl_joy", ctl_joy, 8'b0001_0100);
		joy0 = '0;
		report_test("slapstic type", errs_at_start);
	endtask

	// ############################################################
	// Sequence
	// ############################################################

	initial begin
		reset         = 1'b1;
		load_download = 1'b0;
		load_wr       = 1'b0;
		load_index    = '0;
		load_addr     = '0;
		load_data     = '0;
		main_addr     = '0;
		rom_sel_n     = 4'b1111;
		slap_sel_n    = 1'b1;
		sound_addr    = '0;
		sound_sel_n   = 3'b111;
		video_addr    = '0;
		key_event     = '0;
		joy0          = '0;
		joy1          = '0;
		service       = 1'b0;
		repeat (8) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		tick();
		test_main_rom();
		test_sound_rom();
		test_gfx_pack();
		test_arbitration();
		test_controls();
		test_slap_type();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- source/control_decoder.sv
`timescale 1ns/10ps

module control_decoder import sys1_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  scancode_t  key_event,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  logic       service,
	input  byte_t      slap_type,
	output byte_t      ctl_joy,
	output logic [2:0] ctl_coin_n,
	output logic [4:0] ctl_pb_n,
	output logic       ctl_self_test_n
);

	logic toggle_q;
	logic key_strobe;
	logic pressed;

	// Directions kept as up, down, left, right in bits 3 to 0
	logic [3:0] p1_dir;
	logic [3:0] p2_dir;
	logic       p1_whip;
	logic       p1_jump;
	logic       p2_whip;
	logic       p2_jump;
	logic       coin_l;
	logic       coin_r;
	logic       coin_aux;
	logic [3:0] joy_dir;

	// ############################################################
	// Key event latches
	// ############################################################

	assign key_strobe = (key_event[10] != toggle_q);
	assign pressed    = key_event[9];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Track the current toggle so reset raises no stale event
			toggle_q <= key_event[10];
			p1_dir   <= '0;
			p2_dir   <= '0;
			p1_whip  <= 1'b0;
			p1_jump  <= 1'b0;
			p2_whip  <= 1'b0;
			p2_jump  <= 1'b0;
			coin_l   <= 1'b0;
			coin_r   <= 1'b0;
			coin_aux <= 1'b0;
		end else begin
			toggle_q <= key_event[10];
			if (key_strobe) begin
				case (key_event[8:0])
					KEY_P1_UP:    p1_dir[3] <= pressed;
					KEY_P1_DOWN:  p1_dir[2] <= pressed;
					KEY_P1_LEFT:  p1_dir[1] <= pressed;
					KEY_P1_RIGHT: p1_dir[0] <= pressed;
					KEY_P1_WHIP:  p1_whip   <= pressed;
					KEY_P1_JUMP:  p1_jump   <= pressed;
					KEY_P2_UP:    p2_dir[3] <= pressed;
					KEY_P2_DOWN:  p2_dir[2] <= pressed;
					KEY_P2_LEFT:  p2_dir[1] <= pressed;
					KEY_P2_RIGHT: p2_dir[0] <= pressed;
					KEY_P2_WHIP:  p2_whip   <= pressed;
					KEY_P2_JUMP:  p2_jump   <= pressed;
					KEY_COIN_L:   coin_l    <= pressed;
					KEY_COIN_R:   coin_r    <= pressed;
					KEY_COIN_AUX: coin_aux  <= pressed;
					default: ;  // unlisted keys are ignored
				endcase
			end
		end
	end

	// ############################################################
	// Board control lines
	// ############################################################

	assign joy_dir = p2_dir | p1_dir | joy1[3:0] | joy0[3:0];

	// Type 105 reads its ADC inputs one position higher
	assign ctl_joy = (slap_type == SLAP_SHIFTED) ? {3'b000, joy_dir, 1'b0}
	                                             : {4'b0000, joy_dir};

	// Coin lines, joystick coin button doubles as left coin
	assign ctl_coin_n = {!coin_aux, !coin_r, !(coin_l || joy0[8])};

	// Switches 5 and 4 unused, then jump, P2 whip, P1 whip
	assign ctl_pb_n = {2'b11,
	                   !(p2_jump || p1_jump || joy1[5] || joy0[5]),
	                   !(p2_whip || joy1[5] || joy0[5]),
	                   !(p1_whip || joy1[4] || joy0[4])};

	assign ctl_self_test_n = !service;

endmodule

//--- source/gfx_mem_arbiter.sv
`timescale 1ns/10ps

module gfx_mem_arbiter import sys1_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      loader_active,
	input  logic      pack_we,
	input  gfx_addr_t pack_addr,
	input  dword_t    pack_data,
	input  gfx_addr_t video_addr,
	input  dword_t    gfx_mem_rdata,
	input  logic      gfx_mem_ready,
	output gfx_addr_t gfx_mem_addr,
	output dword_t    gfx_mem_wdata,
	output logic      gfx_mem_we,
	output dword_t    video_data,
	output logic      load_wait
);

	// Held loader write, stable while the port belongs to the loader
	gfx_addr_t wr_addr_q;
	logic      wr_we_q;
	logic      loader_owns;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_we_q <= 1'b0;
		end else begin
			wr_we_q <= pack_we;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pack_we) begin
			wr_addr_q     <= pack_addr;
			gfx_mem_wdata <= pack_data;
		end
	end

	// Last dword may land just after download drops, keep ownership for it
	assign loader_owns = loader_active || wr_we_q;

	assign gfx_mem_addr = loader_owns ? wr_addr_q : video_addr;
	assign gfx_mem_we   = wr_we_q;

	// Video fetch reads straight from the shared memory
	assign video_data = gfx_mem_rdata;

	// Host holds its next byte while memory is busy
	assign load_wait = !gfx_mem_ready;

endmodule

//--- source/rom_bank_set.sv
`timescale 1ns/10ps

module rom_bank_set import sys1_pkg::*; (
	input  logic        clk_sys,
	input  logic [4:0]  main_wr_en,
	input  logic [2:0]  sound_wr_en,
	input  main_addr_t  bank_wr_addr,
	input  word_t       bank_wr_main,
	input  byte_t       bank_wr_sound,
	input  main_addr_t  main_addr,
	input  logic [3:0]  rom_sel_n,
	input  logic        slap_sel_n,
	input  sound_addr_t sound_addr,
	input  logic [2:0]  sound_sel_n,
	output word_t       main_data,
	output byte_t       sound_data
);

	// ROM1 and ROM2 are the 64 KB banks
	logic [1:0] wide_we;
	// System ROM, ROM3 and the slapstic bank are 32 KB
	logic [2:0] narrow_we;

	assign wide_we   = main_wr_en[2:1];
	assign narrow_we = {main_wr_en[4:3], main_wr_en[0]};

	// ############################################################
	// Main CPU word banks
	// ############################################################

	genvar i;

	for (i = 0; i < 2; i++) begin : g_wide
		word_t mem [2**MAIN_WIDE_BITS];
		word_t q;

		always_ff @(posedge clk_sys) begin
			if (wide_we[i]) begin
				mem[bank_wr_addr] <= bank_wr_main;
			end
			q <= mem[main_addr];
		end
	end

	for (i = 0; i < 3; i++) begin : g_narrow
		word_t mem [2**MAIN_NARROW_BITS];
		word_t q;

		always_ff @(posedge clk_sys) begin
			if (narrow_we[i]) begin
				mem[bank_wr_addr[MAIN_NARROW_BITS-1:0]] <= bank_wr_main;
			end
			// Top address bit is ignored by the smaller banks
			q <= mem[main_addr[MAIN_NARROW_BITS-1:0]];
		end
	end

	// ############################################################
	// Sound CPU byte banks
	// ############################################################

	for (i = 0; i < 3; i++) begin : g_sound
		byte_t mem [2**SOUND_BITS];
		byte_t q;

		always_ff @(posedge clk_sys) begin
			if (sound_wr_en[i]) begin
				mem[bank_wr_addr[SOUND_BITS-1:0]] <= bank_wr_sound;
			end
			q <= mem[sound_addr];
		end
	end

	// ############################################################
	// Active-low select multiplexers
	// ############################################################

	// System ROM has top priority, then ROM1 to ROM3, then slapstic
	always_comb begin
		if (!rom_sel_n[0]) begin
			main_data = g_narrow[0].q;
		end else if (!rom_sel_n[1]) begin
			main_data = g_wide[0].q;
		end else if (!rom_sel_n[2]) begin
			main_data = g_wide[1].q;
		end else if (!rom_sel_n[3]) begin
			main_data = g_narrow[1].q;
		end else if (!slap_sel_n) begin
			main_data = g_narrow[2].q;
		end else begin
			main_data = '0;
		end
	end

	// Lowest select bit wins
	always_comb begin
		if (!sound_sel_n[0]) begin
			sound_data = g_sound[0].q;
		end else if (!sound_sel_n[1]) begin
			sound_data = g_sound[1].q;
		end else if (!sound_sel_n[2]) begin
			sound_data = g_sound[2].q;
		end else begin
			sound_data = '0;
		end
	end

endmodule

//--- source/rom_loader.sv
`timescale 1ns/10ps

module rom_loader import sys1_pkg::*; (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            load_download,
	input  logic            load_wr,
	input  byte_t           load_index,
	input  load_addr_t      load_addr,
	input  byte_t           load_data,
	output logic            loader_active,
	output logic [4:0]      main_wr_en,
	output logic [2:0]      sound_wr_en,
	output main_addr_t      bank_wr_addr,
	output word_t           bank_wr_main,
	output byte_t           bank_wr_sound,
	output logic            pack_we,
	output gfx_addr_t       pack_addr,
	output dword_t          pack_data,
	output logic            slap_type_unused_n,
	output byte_t           slap_type
);

	// Last three index-0 bytes, oldest in the top byte
	logic [23:0] acc;

	logic       rom_byte;
	logic       slap_byte;
	logic [4:0] main_hit;
	logic [2:0] sound_hit;

	// ############################################################
	// Stream qualification and region decode
	// ############################################################

	assign rom_byte  = load_wr && load_download && (load_index == INDEX_ROM);
	assign slap_byte = load_wr && (load_index == INDEX_SLAP_TYPE);

	// Bank order matches the select order: ROM0, ROM1, ROM2, ROM3, SLAP
	assign main_hit[0] = (load_addr[24:15] == REGION_ROM0[24:15]);
	assign main_hit[1] = (load_addr[24:16] == REGION_ROM1[24:16]);
	assign main_hit[2] = (load_addr[24:16] == REGION_ROM2[24:16]);
	assign main_hit[3] = (load_addr[24:15] == REGION_ROM3[24:15]);
	assign main_hit[4] = (load_addr[24:15] == REGION_SLAP[24:15]);

	// Sound banks are 16 KB each
	assign sound_hit[0] = (load_addr[24:14] == REGION_SND0[24:14]);
	assign sound_hit[1] = (load_addr[24:14] == REGION_SND1[24:14]);
	assign sound_hit[2] = (load_addr[24:14] == REGION_SND2[24:14]);

	// Slapstic type is not a real output pin, flag shows non-default type
	assign slap_type_unused_n = (slap_type == SLAP_DEFAULT);

	// ############################################################
	// Strobes and control registers
	// ############################################################

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loader_active <= 1'b0;
			main_wr_en    <= '0;
			sound_wr_en   <= '0;
			pack_we       <= 1'b0;
			slap_type     <= SLAP_DEFAULT;
		end else begin
			loader_active <= load_download;
			// Word complete on the odd byte
			main_wr_en    <= (rom_byte && load_addr[0]) ? main_hit : 5'b0;
			sound_wr_en   <= rom_byte ? sound_hit : 3'b0;
			// Dword complete on the fourth byte
			pack_we       <= rom_byte && (&load_addr[1:0]);
			if (slap_byte) begin
				slap_type <= load_data;
			end
		end
	end

	// ############################################################
	// Byte history and write payload
	// ############################################################

	always_ff @(posedge clk_sys) begin
		if (rom_byte) begin
			acc           <= {acc[15:0], load_data};
			bank_wr_main  <= {acc[7:0], load_data};
			bank_wr_sound <= load_data;
			// Sound banks take a byte offset, main banks a word offset
			if (|sound_hit) begin
				bank_wr_addr <= {1'b0, load_addr[SOUND_BITS-1:0]};
			end else begin
				bank_wr_addr <= load_addr[15:1];
			end
			pack_data     <= {acc, load_data};
			pack_addr     <= load_addr[24:2];
		end
	end

endmodule

//--- source/sys1_pkg.sv
package sys1_pkg;

	// ############################################################
	// Vector types
	// ############################################################

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [31:0] dword_t;
	typedef logic [24:0] load_addr_t;
	typedef logic [22:0] gfx_addr_t;
	typedef logic [14:0] main_addr_t;
	typedef logic [13:0] sound_addr_t;
	typedef logic [11:0] joy_t;

	// Bit 10 toggles per event, bit 9 is pressed, bits 8:0 the code
	typedef logic [10:0] scancode_t;

	// ############################################################
	// Loader stream layout
	// ############################################################

	// Byte offsets of each cartridge region in the index-0 stream
	localparam load_addr_t REGION_ROM1 = 25'h008_0000;
	localparam load_addr_t REGION_ROM2 = 25'h009_0000;
	localparam load_addr_t REGION_ROM3 = 25'h00A_0000;
	localparam load_addr_t REGION_SLAP = 25'h00A_8000;
	localparam load_addr_t REGION_ROM0 = 25'h00B_0000;
	localparam load_addr_t REGION_SND0 = 25'h00B_8000;
	localparam load_addr_t REGION_SND1 = 25'h00B_C000;
	localparam load_addr_t REGION_SND2 = 25'h00C_0000;

	// Bank depths as address widths
	localparam int MAIN_WIDE_BITS   = 15;
	localparam int MAIN_NARROW_BITS = 14;
	localparam int SOUND_BITS       = 14;

	// Stream index values
	localparam byte_t INDEX_ROM       = 8'd0;
	localparam byte_t INDEX_SLAP_TYPE = 8'd1;

	// Slapstic type, 105 is the board default
	localparam byte_t SLAP_DEFAULT = 8'd105;
	localparam byte_t SLAP_SHIFTED = 8'd105;

	// ############################################################
	// Keyboard scancodes
	// ############################################################

	localparam logic [8:0] KEY_P1_UP    = 9'h175;
	localparam logic [8:0] KEY_P1_DOWN  = 9'h172;
	localparam logic [8:0] KEY_P1_LEFT  = 9'h16B;
	localparam logic [8:0] KEY_P1_RIGHT = 9'h174;
	localparam logic [8:0] KEY_P1_WHIP  = 9'h014;
	localparam logic [8:0] KEY_P1_JUMP  = 9'h011;
	localparam logic [8:0] KEY_P2_UP    = 9'h02D;
	localparam logic [8:0] KEY_P2_DOWN  = 9'h02B;
	localparam logic [8:0] KEY_P2_LEFT  = 9'h023;
	localparam logic [8:0] KEY_P2_RIGHT = 9'h034;
	localparam logic [8:0] KEY_P2_WHIP  = 9'h01C;
	localparam logic [8:0] KEY_P2_JUMP  = 9'h01B;
	localparam logic [8:0] KEY_COIN_L   = 9'h02E;
	localparam logic [8:0] KEY_COIN_R   = 9'h036;
	localparam logic [8:0] KEY_COIN_AUX = 9'h03D;

endpackage

//--- source/sys1_rom_top.sv
`timescale 1ns/10ps

module sys1_rom_top import sys1_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	// Host loader stream
	input  logic        load_download,
	input  logic        load_wr,
	input  byte_t       load_index,
	input  load_addr_t  load_addr,
	input  byte_t       load_data,
	output logic        load_wait,
	// Main and sound CPU ROM access
	input  main_addr_t  main_addr,
	input  logic [3:0]  rom_sel_n,
	input  logic        slap_sel_n,
	output word_t       main_data,
	input  sound_addr_t sound_addr,
	input  logic [2:0]  sound_sel_n,
	output byte_t       sound_data,
	// Video fetch and external graphics memory
	input  gfx_addr_t   video_addr,
	output dword_t      video_data,
	output gfx_addr_t   gfx_mem_addr,
	output dword_t      gfx_mem_wdata,
	output logic        gfx_mem_we,
	input  dword_t      gfx_mem_rdata,
	input  logic        gfx_mem_ready,
	// Player controls
	input  scancode_t   key_event,
	input  joy_t        joy0,
	input  joy_t        joy1,
	input  logic        service,
	output byte_t       ctl_joy,
	output logic [2:0]  ctl_coin_n,
	output logic [4:0]  ctl_pb_n,
	output logic        ctl_self_test_n
);

	logic       loader_active;
	logic [4:0] main_wr_en;
	logic [2:0] sound_wr_en;
	main_addr_t bank_wr_addr;
	word_t      bank_wr_main;
	byte_t      bank_wr_sound;
	logic       pack_we;
	gfx_addr_t  pack_addr;
	dword_t     pack_data;
	byte_t      slap_type;

	rom_loader loader_i (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.load_download      (load_download),
		.load_wr            (load_wr),
		.load_index         (load_index),
		.load_addr          (load_addr),
		.load_data          (load_data),
		.loader_active      (loader_active),
		.main_wr_en         (main_wr_en),
		.sound_wr_en        (sound_wr_en),
		.bank_wr_addr       (bank_wr_addr),
		.bank_wr_main       (bank_wr_main),
		.bank_wr_sound      (bank_wr_sound),
		.pack_we            (pack_we),
		.pack_addr          (pack_addr),
		.pack_data          (pack_data),
		.slap_type_unused_n (),
		.slap_type          (slap_type)
	);

	rom_bank_set banks_i (
		.clk_sys       (clk_sys),
		.main_wr_en    (main_wr_en),
		.sound_wr_en   (sound_wr_en),
		.bank_wr_addr  (bank_wr_addr),
		.bank_wr_main  (bank_wr_main),
		.bank_wr_sound (bank_wr_sound),
		.main_addr     (main_addr),
		.rom_sel_n     (rom_sel_n),
		.slap_sel_n    (slap_sel_n),
		.sound_addr    (sound_addr),
		.sound_sel_n   (sound_sel_n),
		.main_data     (main_data),
		.sound_data    (sound_data)
	);

	gfx_mem_arbiter arbiter_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.loader_active (loader_active),
		.pack_we       (pack_we),
		.pack_addr     (pack_addr),
		.pack_data     (pack_data),
		.video_addr    (video_addr),
		.gfx_mem_rdata (gfx_mem_rdata),
		.gfx_mem_ready (gfx_mem_ready),
		.gfx_mem_addr  (gfx_mem_addr),
		.gfx_mem_wdata (gfx_mem_wdata),
		.gfx_mem_we    (gfx_mem_we),
		.video_data    (video_data),
		.load_wait     (load_wait)
	);

	control_decoder controls_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.key_event       (key_event),
		.joy0            (joy0),
		.joy1            (joy1),
		.service         (service),
		.slap_type       (slap_type),
		.ctl_joy         (ctl_joy),
		.ctl_coin_n      (ctl_coin_n),
		.ctl_pb_n        (ctl_pb_n),
		.ctl_self_test_n (ctl_self_test_n)
	);

endmodule
